// ==== common/mem_op_pkg.sv ====
`default_nettype none

package mem_op_pkg;

    typedef logic [2:0] mem_type_t;

    // Store codes and every other value is a load
    localparam mem_type_t ST_W = 3'b001;
    localparam mem_type_t ST_B = 3'b110;
    localparam mem_type_t ST_H = 3'b111;

    // Byte offset inside a 16-byte line
    typedef struct packed {
        logic [1:0] word_idx;
        logic [1:0] byte_idx;
    } line_offset_t;

endpackage

`default_nettype wire

// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    ////////////////////
    // Geometry
    localparam int NUM_WAYS      = 2;
    localparam int LINE_BYTES    = 16;
    localparam int OFFSET_W      = 4;
    localparam int WORD_OFFSET_W = 2;

    // Way 0 in the low half, way 1 in the high half
    typedef logic [NUM_WAYS*LINE_BYTES-1:0] mem_we_t;
    typedef logic [NUM_WAYS-1:0]            way_mask_t;

    typedef enum logic [2:0] {
        IDLE       = 3'h0,
        LOOKUP     = 3'h1,
        MISS       = 3'h2,
        REFILL     = 3'h3,
        WAIT_WRITE = 3'h4,
        MISS_A     = 3'h5
    } dcache_state_t;

    ////////////////////
    // Grouped control
    typedef struct packed {
        logic rvalid;
        logic wvalid;
    } cache_req_t;

    typedef struct packed {
        logic                  rvalid_pipe;
        logic                  wvalid_pipe;
        logic                  uncache_pipe;
        mem_op_pkg::mem_type_t mem_type_pipe;
        logic [31:0]           address;
    } pipe_info_t;

    typedef struct packed {
        logic rbuf_we;
        logic mbuf_we;
        logic wbuf_we;
        logic data_from_mem_sel;
        logic rready;
        logic wready;
        logic lru_update;
        logic miss_lru_update;
        logic miss_lru_way;
        logic wfsm_en;
        logic wfsm_rset;
    } dcache_ctrl_t;

endpackage

`default_nettype wire

// ==== src/way_write_mask.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_write_mask
    import dcache_pkg::*;
    import mem_op_pkg::*;
(
    input  wire logic       store_hit,
    input  wire logic       refill,
    input  wire pipe_info_t pipe,
    input  wire way_mask_t  hit,
    input  wire logic       way_sel,
    output mem_we_t         mem_we,
    output way_mask_t       tag_dv_we
);

    line_offset_t          off;
    logic [LINE_BYTES-1:0] store_be;
    logic [LINE_BYTES-1:0] way_be;
    logic                  tgt_way;

    assign off = pipe.address[OFFSET_W-1:0];

    ////////////////////
    // Store byte enables
    always_comb begin
        case (pipe.mem_type_pipe)
            ST_W: begin
                store_be = LINE_BYTES'(4'hf) << {off.word_idx, 2'b00};
            end
            ST_H: begin
                // misaligned halfword writes nothing
                store_be = off.byte_idx[0] ? '0 : LINE_BYTES'(2'b11) << off;
            end
            ST_B: begin
                store_be = LINE_BYTES'(1'b1) << off;
            end
            default: begin
                store_be = '0;
            end
        endcase
    end

    // Refill targets the victim and a store hit prefers way 0
    assign tgt_way = refill ? way_sel : ~hit[0];
    assign way_be  = refill ? '1 : store_be;

    ////////////////////
    // Place into the way's half
    always_comb begin
        mem_we    = '0;
        tag_dv_we = '0;
        if (store_hit || refill) begin
            mem_we[tgt_way*LINE_BYTES +: LINE_BYTES] = way_be;
            tag_dv_we[tgt_way]                       = 1'b1;
        end
    end

    strobe_excl: assert #0 (!(store_hit && refill))
        else $error("store_hit and refill active together");

endmodule

`default_nettype wire

// ==== fsm/dcache_main_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_main_fsm
    import dcache_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire cache_req_t       req,
    input  wire pipe_info_t       pipe,
    input  wire way_mask_t        hit,
    input  wire logic             way_sel,
    input  wire logic             write_finish,
    input  wire logic             d_arready,
    input  wire logic             d_rvalid,
    input  wire logic             d_rlast,
    output logic                  d_arvalid,
    output logic [ADDR_WIDTH-1:0] d_araddr,
    output logic                  d_rready,
    output dcache_ctrl_t          ctrl,
    output logic                  store_hit,
    output logic                  refill
);

    dcache_state_t state;
    dcache_state_t state_next;
    logic          new_req;
    logic          any_hit;

    assign new_req = req.rvalid | req.wvalid;
    assign any_hit = |hit;

    ////////////////////
    // State register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // Next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (new_req) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (pipe.uncache_pipe) begin
                    // Uncached writes skip the read entirely
                    state_next = pipe.rvalid_pipe ? MISS_A : WAIT_WRITE;
                end else if (!any_hit) begin
                    state_next = MISS_A;
                end else if (!new_req) begin
                    state_next = IDLE;
                end
            end
            MISS_A: begin
                if (d_arready) begin
                    state_next = MISS;
                end
            end
            MISS: begin
                if (d_rvalid && d_rlast) begin
                    state_next = pipe.uncache_pipe ? WAIT_WRITE : REFILL;
                end
            end
            REFILL: begin
                state_next = WAIT_WRITE;
            end
            WAIT_WRITE: begin
                if (write_finish) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    ////////////////////
    // Outputs per state
    always_comb begin
        ctrl                   = '0;
        ctrl.data_from_mem_sel = 1'b1;
        d_arvalid              = 1'b0;
        d_araddr               = '0;
        d_rready               = 1'b0;
        case (state)
            IDLE: begin
                ctrl.rbuf_we   = 1'b1;
                ctrl.rready    = 1'b1;
                ctrl.wready    = 1'b1;
                ctrl.wfsm_rset = 1'b1;
            end
            LOOKUP: begin
                if (pipe.uncache_pipe) begin
                    ctrl.wfsm_en = !pipe.rvalid_pipe;
                end else if (any_hit) begin
                    ctrl.rbuf_we           = 1'b1;
                    ctrl.data_from_mem_sel = 1'b0;
                    ctrl.rready            = !pipe.wvalid_pipe;
                    ctrl.wready            = pipe.wvalid_pipe;
                    ctrl.lru_update        = 1'b1;
                end else begin
                    // Capture miss info and start victim write-back
                    ctrl.mbuf_we = 1'b1;
                    ctrl.wbuf_we = 1'b1;
                    ctrl.wfsm_en = 1'b1;
                end
            end
            MISS_A: begin
                d_arvalid = 1'b1;
                if (pipe.uncache_pipe) begin
                    d_araddr = {pipe.address[ADDR_WIDTH-1:WORD_OFFSET_W],
                                {WORD_OFFSET_W{1'b0}}};
                end else begin
                    d_araddr = {pipe.address[ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};
                end
            end
            MISS: begin
                d_rready = 1'b1;
            end
            REFILL: begin
                ctrl.miss_lru_update = 1'b1;
                ctrl.miss_lru_way    = way_sel;
            end
            default: begin
            end
        endcase
    end

    // Strobes to the mask decoder
    assign store_hit = (state == LOOKUP) && any_hit && !pipe.uncache_pipe && pipe.wvalid_pipe;
    assign refill    = (state == REFILL);

    ////////////////////
    // Checks
    araddr_stable: assert property (@(posedge clk) disable iff (!rstn)
        d_arvalid && !d_arready |=> d_arvalid && $stable(d_araddr))
        else $error("d_araddr changed while read request pending");

    refill_once: assert property (@(posedge clk) disable iff (!rstn)
        state == REFILL |=> state != REFILL)
        else $error("REFILL held for more than one cycle");

endmodule

`default_nettype wire

// ==== src/dcache_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl_top
    import dcache_pkg::*;
#(
    parameter int ADDR_WIDTH = 32
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire cache_req_t       req,
    input  wire pipe_info_t       pipe,
    input  wire way_mask_t        hit,
    input  wire logic             way_sel,
    input  wire logic             write_finish,
    input  wire logic             d_arready,
    input  wire logic             d_rvalid,
    input  wire logic             d_rlast,
    output logic                  d_arvalid,
    output logic [ADDR_WIDTH-1:0] d_araddr,
    output logic                  d_rready,
    output dcache_ctrl_t          ctrl,
    output mem_we_t               mem_we,
    output way_mask_t             tag_dv_we
);

    logic store_hit;
    logic refill;

    dcache_main_fsm #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_dcache_main_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req),
        .pipe         (pipe),
        .hit          (hit),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .d_arready    (d_arready),
        .d_rvalid     (d_rvalid),
        .d_rlast      (d_rlast),
        .d_arvalid    (d_arvalid),
        .d_araddr     (d_araddr),
        .d_rready     (d_rready),
        .ctrl         (ctrl),
        .store_hit    (store_hit),
        .refill       (refill)
    );

    way_write_mask i_way_write_mask (
        .store_hit (store_hit),
        .refill    (refill),
        .pipe      (pipe),
        .hit       (hit),
        .way_sel   (way_sel),
        .mem_we    (mem_we),
        .tag_dv_we (tag_dv_we)
    );

endmodule

`default_nettype wire

// ==== dv/tb_dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_ctrl
    import dcache_pkg::*;
    import mem_op_pkg::*;
();

    localparam int ADDR_WIDTH = 32;
    localparam int TIMEOUT    = 64;

    logic                  clk;
    logic                  rstn;
    cache_req_t            req;
    pipe_info_t            pipe;
    way_mask_t             hit;
    logic                  way_sel;
    logic                  write_finish;
    logic                  d_arready;
    logic                  d_rvalid;
    logic                  d_rlast;
    logic                  d_arvalid;
    logic [ADDR_WIDTH-1:0] d_araddr;
    logic                  d_rready;
    dcache_ctrl_t          ctrl;
    mem_we_t               mem_we;
    way_mask_t             tag_dv_we;

    integer seed;
    int     errors;
    int     test_errors;
    int     tests_run;

    dcache_ctrl_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_dcache_ctrl_top (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req),
        .pipe         (pipe),
        .hit          (hit),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .d_arready    (d_arready),
        .d_rvalid     (d_rvalid),
        .d_rlast      (d_rlast),
        .d_arvalid    (d_arvalid),
        .d_araddr     (d_araddr),
        .d_rready     (d_rready),
        .ctrl         (ctrl),
        .mem_we       (mem_we),
        .tag_dv_we    (tag_dv_we)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Helpers
    task automatic log_mismatch(input string test, input string what,
                                input logic [63:0] exp, input logic [63:0] act);
        $display("CHECK FAILED %s: %s expected %h actual %h", test, what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic timeout_error(input string test, input string what);
        $display("Test %s gave up waiting for %s", test, what);
        errors++;
        test_errors++;
    endtask

    task automatic close_test(input string test);
        $display("Test %s finished with %0d failures", test, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // Bytes covered by a store counted from its first byte
    function automatic logic [15:0] store_bytes(input mem_type_t t, input logic [3:0] off);
        logic [15:0] be;
        int          first;
        int          size;
        first = off;
        size  = 0;
        if (t == ST_W) begin
            first = {off[3:2], 2'b00};
            size  = 4;
        end else if (t == ST_H) begin
            size = off[0] ? 0 : 2;
        end else if (t == ST_B) begin
            size = 1;
        end
        for (int i = 0; i < 16; i++) begin
            be[i] = (i >= first) && (i < first + size);
        end
        return be;
    endfunction

    // Ends on the falling edge of the LOOKUP cycle
    task automatic issue_request(input logic rd, input logic wr, input pipe_info_t p,
                                 input way_mask_t h);
        @(posedge clk);
        req.rvalid <= rd;
        req.wvalid <= wr;
        pipe       <= p;
        hit        <= h;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
    endtask

    task automatic wait_idle(input string test);
        int cnt;
        cnt = 0;
        while (!(ctrl.rready && ctrl.wready && ctrl.wfsm_rset) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!(ctrl.rready && ctrl.wready && ctrl.wfsm_rset))
            timeout_error(test, "the return to IDLE");
    endtask

    task automatic finish_write(input string test);
        @(posedge clk);
        write_finish <= 1'b1;
        @(negedge clk);
        wait_idle(test);
        @(posedge clk);
        write_finish <= 1'b0;
        @(negedge clk);
    endtask

    // Memory side of one read that stalls, accepts and then streams beats
    task automatic read_burst(input string test, input logic [31:0] exp_addr,
                              input int hold, input int beats);
        int cnt;
        cnt = 0;
        while (!d_arvalid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!d_arvalid)
            timeout_error(test, "d_arvalid");
        for (int k = 0; k < hold; k++) begin
            if ({d_arvalid, d_araddr} !== {1'b1, exp_addr})
                log_mismatch(test, "d_arvalid/d_araddr", {1'b1, exp_addr},
                             {d_arvalid, d_araddr});
            @(negedge clk);
        end
        @(posedge clk);
        d_arready <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!d_rready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!d_rready)
            timeout_error(test, "d_rready");
        for (int b = 0; b < beats; b++) begin
            @(posedge clk);
            d_arready <= 1'b0;
            d_rvalid  <= 1'b1;
            d_rlast   <= (b == beats - 1);
            @(negedge clk);
            if (d_rready !== 1'b1)
                log_mismatch(test, "d_rready", 1'b1, d_rready);
        end
        @(posedge clk);
        d_arready <= 1'b0;
        d_rvalid  <= 1'b0;
        d_rlast   <= 1'b0;
        @(negedge clk);
    endtask

    ////////////////////
    // Tests
    task automatic reset_state();
        dcache_ctrl_t exp;
        exp                   = '0;
        exp.rbuf_we           = 1'b1;
        exp.data_from_mem_sel = 1'b1;
        exp.rready            = 1'b1;
        exp.wready            = 1'b1;
        exp.wfsm_rset         = 1'b1;
        rstn <= 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (ctrl !== exp)
            log_mismatch("reset", "ctrl", exp, ctrl);
        if ({mem_we, tag_dv_we, d_arvalid, d_rready} !== '0)
            log_mismatch("reset", "mem_we/tag_dv_we/d_arvalid/d_rready", 0,
                         {mem_we, tag_dv_we, d_arvalid, d_rready});
        close_test("reset");
    endtask

    task automatic store_hits();
        pipe_info_t  p;
        mem_type_t   types [3];
        mem_type_t   t;
        logic [3:0]  off;
        way_mask_t   h;
        logic        way;
        logic [15:0] be;
        types = '{ST_W, ST_H, ST_B};
        for (int n = 0; n < 13; n++) begin
            t   = types[$unsigned($random(seed)) % 3];
            off = 4'($random(seed));
            h   = way_mask_t'($unsigned($random(seed)) % 3 + 1);
            // Last round is a misaligned halfword
            if (n == 12) begin
                t   = ST_H;
                off = 4'h5;
            end
            way             = !h[0];
            be              = store_bytes(t, off);
            p               = '0;
            p.wvalid_pipe   = 1'b1;
            p.mem_type_pipe = t;
            p.address       = {28'($random(seed)), off};
            issue_request(1'b0, 1'b1, p, h);
            if (mem_we !== (way ? {be, 16'h0000} : {16'h0000, be}))
                log_mismatch("store_hit", "mem_we", way ? {be, 16'h0000} : {16'h0000, be},
                             mem_we);
            if (tag_dv_we !== {way, !way})
                log_mismatch("store_hit", "tag_dv_we", {way, !way}, tag_dv_we);
            if ({ctrl.wready, ctrl.lru_update} !== 2'b11)
                log_mismatch("store_hit", "wready/lru_update", 2'b11,
                             {ctrl.wready, ctrl.lru_update});
            @(negedge clk);
            wait_idle("store_hit");
        end
        close_test("store_hit");
    endtask

    task automatic load_hits();
        pipe_info_t p;
        for (int n = 0; n < 4; n++) begin
            p               = '0;
            p.rvalid_pipe   = 1'b1;
            p.mem_type_pipe = (n % 2) ? 3'b010 : 3'b000;
            p.address       = $random(seed);
            issue_request(1'b1, 1'b0, p, way_mask_t'(n % 3 + 1));
            if ({mem_we, tag_dv_we} !== '0)
                log_mismatch("load_hit", "mem_we/tag_dv_we", 0, {mem_we, tag_dv_we});
            if ({ctrl.rready, ctrl.lru_update} !== 2'b11)
                log_mismatch("load_hit", "rready/lru_update", 2'b11,
                             {ctrl.rready, ctrl.lru_update});
            @(negedge clk);
            if ({ctrl.rready, ctrl.wready, ctrl.wfsm_rset, ctrl.lru_update} !== 4'b1110)
                log_mismatch("load_hit", "IDLE controls", 4'b1110,
                             {ctrl.rready, ctrl.wready, ctrl.wfsm_rset, ctrl.lru_update});
        end
        close_test("load_hit");
    endtask

    task automatic cached_miss();
        pipe_info_t p;
        logic       ws;
        mem_we_t    exp_we;
        p                = '0;
        p.rvalid_pipe    = 1'b1;
        p.address        = $random(seed);
        // Nonzero line offset so the alignment shows
        p.address[3:0]   = 4'h6;
        ws               = 1'($random(seed));
        exp_we           = ws ? {16'hffff, 16'h0000} : {16'h0000, 16'hffff};
        @(posedge clk);
        way_sel <= ws;
        issue_request(1'b1, 1'b0, p, 2'b00);
        if ({ctrl.mbuf_we, ctrl.wbuf_we} !== 2'b11)
            log_mismatch("cached_miss", "mbuf_we/wbuf_we", 2'b11, {ctrl.mbuf_we, ctrl.wbuf_we});
        @(negedge clk);
        if ({ctrl.mbuf_we, ctrl.wbuf_we} !== 2'b00)
            log_mismatch("cached_miss", "mbuf_we/wbuf_we after LOOKUP", 2'b00,
                         {ctrl.mbuf_we, ctrl.wbuf_we});
        read_burst("cached_miss", p.address & 32'hffff_fff0, 3, 4);
        // Refill cycle into the victim way
        if ({mem_we, tag_dv_we} !== {exp_we, ws, !ws})
            log_mismatch("cached_miss", "refill mem_we/tag_dv_we", {exp_we, ws, !ws},
                         {mem_we, tag_dv_we});
        if ({ctrl.miss_lru_update, ctrl.miss_lru_way, d_rready} !== {1'b1, ws, 1'b0})
            log_mismatch("cached_miss", "miss_lru_update/way/d_rready", {1'b1, ws, 1'b0},
                         {ctrl.miss_lru_update, ctrl.miss_lru_way, d_rready});
        @(negedge clk);
        if ({mem_we, ctrl.miss_lru_update, ctrl.rready} !== '0)
            log_mismatch("cached_miss", "after refill", 0,
                         {mem_we, ctrl.miss_lru_update, ctrl.rready});
        finish_write("cached_miss");
        close_test("cached_miss");
    endtask

    task automatic uncached_read();
        pipe_info_t p;
        p              = '0;
        p.rvalid_pipe  = 1'b1;
        p.uncache_pipe = 1'b1;
        p.address      = $random(seed);
        // Word and byte offsets both nonzero
        p.address[3:0] = 4'hd;
        issue_request(1'b1, 1'b0, p, 2'b00);
        @(negedge clk);
        read_burst("uncached_read", p.address & 32'hffff_fffc, 1, 1);
        repeat (2) begin
            if ({mem_we, tag_dv_we} !== '0)
                log_mismatch("uncached_read", "mem_we/tag_dv_we", 0, {mem_we, tag_dv_we});
            @(negedge clk);
        end
        finish_write("uncached_read");
        close_test("uncached_read");
    endtask

    task automatic uncached_write();
        pipe_info_t p;
        p               = '0;
        p.wvalid_pipe   = 1'b1;
        p.uncache_pipe  = 1'b1;
        p.mem_type_pipe = ST_W;
        p.address       = $random(seed);
        issue_request(1'b0, 1'b1, p, 2'b01);
        if ({ctrl.wfsm_en, d_arvalid, mem_we} !== {1'b1, 33'h0})
            log_mismatch("uncached_write", "wfsm_en/d_arvalid/mem_we", {1'b1, 33'h0},
                         {ctrl.wfsm_en, d_arvalid, mem_we});
        repeat (3) begin
            @(negedge clk);
            if ({ctrl.wfsm_en, d_arvalid} !== 2'b00)
                log_mismatch("uncached_write", "wfsm_en/d_arvalid", 2'b00,
                             {ctrl.wfsm_en, d_arvalid});
        end
        finish_write("uncached_write");
        close_test("uncached_write");
    endtask

    initial begin
        seed         = 32'hd065;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        clk          = 1'b0;
        rstn         = 1'b0;
        req          = '0;
        pipe         = '0;
        hit          = '0;
        way_sel      = 1'b0;
        write_finish = 1'b0;
        d_arready    = 1'b0;
        d_rvalid     = 1'b0;
        d_rlast      = 1'b0;
        reset_state();
        store_hits();
        load_hits();
        cached_miss();
        uncached_read();
        uncached_write();
        $display("Tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/mem_op_pkg.sv
common/dcache_pkg.sv
src/way_write_mask.sv
fsm/dcache_main_fsm.sv
src/dcache_ctrl_top.sv
dv/tb_dcache_ctrl.sv

// ==== Bender.yml ====
package:
  name: dcache_ctrl

sources:
  - files:
      - common/mem_op_pkg.sv
      - common/dcache_pkg.sv
      - src/way_write_mask.sv
      - fsm/dcache_main_fsm.sv
      - src/dcache_ctrl_top.sv
  - target: simulation
    files:
      - dv/tb_dcache_ctrl.sv
